// File: compile.f
logic/mem_access_pkg.sv
logic/mips_exc_pkg.sv
logic/addr_translate.sv
logic/store_lane.sv
logic/ll_sc_monitor.sv
logic/access_commit.sv
logic/mem1_stage.sv
verification/mem1_stage_tb.sv

// File: logic/access_commit.sv
`timescale 1ns/10ps

module access_commit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mem_access_pkg::acc_req_t  acc,
    input  logic                      interrupt,
    input  logic                      prior_exc,
    input  mips_exc_pkg::exc_code_e   prior_code,
    input  logic                      eret,
    input  mem_access_pkg::word_t     paddr,
    input  logic                      uncached,
    input  logic                      tlb_refill,
    input  logic                      tlb_invalid,
    input  logic                      tlb_modify,
    input  mem_access_pkg::lane_out_t lanes [mem_access_pkg::num_lanes],
    input  logic                      sc_ok,
    output logic                      link_clear,
    output mem_access_pkg::mem_req_t  mem_req,
    output mips_exc_pkg::exc_report_t exc,
    output logic                      sc_success
);
    import mem_access_pkg::*;
    import mips_exc_pkg::*;

    logic        store;
    logic        misaligned;
    logic        adel;
    logic        ades;
    logic        sc_fail;
    strb_t       wstrb;
    word_t       wdata;
    exc_report_t exc_next;
    mem_req_t    req_next;
    logic        sc_next;

    assign store = is_store(acc.kind);

    always_comb begin
        case (acc.kind)
            LH, LHU, SH:    misaligned = acc.vaddr[0];
            LW, LL, SW, SC: misaligned = (acc.vaddr[1:0] != 2'b00);
            default:        misaligned = 1'b0;   // byte and swl/swr
        endcase
    end

    assign adel = misaligned & ~store;
    assign ades = misaligned & store;

    // fixed priority, highest first
    always_comb begin
        exc_next = '0;
        if (acc.valid) begin
            exc_next.valid    = 1'b1;
            exc_next.badvaddr = acc.vaddr;
            if (interrupt) begin
                exc_next.code     = EXC_INT;
                exc_next.badvaddr = '0;
            end else if (prior_exc) begin
                exc_next.code     = prior_code;
                exc_next.badvaddr = acc.pc;
            end else if (ades) begin
                exc_next.code = EXC_ADES;
            end else if (adel) begin
                exc_next.code = EXC_ADEL;
            end else if (tlb_invalid) begin
                exc_next.code   = store ? EXC_TLBS : EXC_TLBL;
                exc_next.refill = tlb_refill;
            end else if (tlb_modify) begin
                exc_next.code = EXC_MOD;
            end else begin
                exc_next = '0;
            end
        end
    end

    assign link_clear = exc_next.valid | eret;

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            wstrb[i]         = lanes[i].en;
            wdata[8*i +: 8]  = lanes[i].data;
        end
    end

    assign sc_fail = (acc.kind == SC) && !sc_ok;   // failed sc stays off the bus

    always_comb begin
        req_next = '0;
        if (acc.valid && !exc_next.valid && !sc_fail) begin
            req_next.valid    = 1'b1;
            req_next.write    = store;
            req_next.uncached = uncached;
            req_next.size     = access_size(acc.kind);
            req_next.paddr    = paddr;
            req_next.wstrb    = wstrb;
            req_next.wdata    = wdata;
        end
    end

    assign sc_next = acc.valid && (acc.kind == SC) && !exc_next.valid && sc_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_req    <= '0;
            exc        <= '0;
            sc_success <= 1'b0;
        end else begin
            mem_req    <= req_next;
            exc        <= exc_next;
            sc_success <= sc_next;
        end
    end

    a_one_outcome: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req.valid && exc.valid));

    a_read_no_strb: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.valid && !mem_req.write |-> mem_req.wstrb == '0);

endmodule

// File: logic/addr_translate.sv
`timescale 1ns/10ps

module addr_translate (
    input  mem_access_pkg::acc_req_t    acc,
    input  mem_access_pkg::tlb_result_t tlb,
    input  mem_access_pkg::cattr_t      k0_cattr,
    output mem_access_pkg::word_t       paddr,
    output logic                        uncached,
    output logic                        tlb_refill,
    output logic                        tlb_invalid,
    output logic                        tlb_modify
);
    import mem_access_pkg::*;
    import mips_exc_pkg::*;

    logic [2:0] seg;
    logic       kseg0;
    logic       kseg1;
    logic       mapped;
    logic       store;
    logic       tlb_hit;

    assign seg   = acc.vaddr[31:29];
    assign kseg0 = (seg == seg_kseg0);
    assign kseg1 = (seg == seg_kseg1);

    // kuseg and kseg2/3 go through the tlb
    assign mapped = ~acc.vaddr[31] | (acc.vaddr[31] & acc.vaddr[30]);

    always_comb begin
        if (mapped)
            paddr = {tlb.pfn, acc.vaddr[11:0]};
        else
            paddr = {3'b000, acc.vaddr[28:0]};
    end

    always_comb begin
        uncached = 1'b0;
        if (kseg1)
            uncached = 1'b1;
        else if (kseg0)
            uncached = (k0_cattr != cattr_cacheable);
        else if (mapped)
            uncached = (tlb.cattr != cattr_cacheable);
    end

    assign store   = is_store(acc.kind);   // sc included
    assign tlb_hit = tlb.found & tlb.valid;

    // faults only matter for a real access
    assign tlb_refill  = acc.valid & mapped & ~tlb.found;
    assign tlb_invalid = acc.valid & mapped & ~tlb_hit;
    assign tlb_modify  = acc.valid & mapped & tlb_hit & ~tlb.dirty & store;

endmodule

// File: logic/ll_sc_monitor.sv
`timescale 1ns/10ps

module ll_sc_monitor (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_access_pkg::acc_req_t acc,
    input  logic                     link_clear,
    output logic                     sc_ok
);
    import mem_access_pkg::*;

    logic  link_bit;
    word_t link_addr;
    logic  ll_take;

    assign ll_take = acc.valid && (acc.kind == LL);

    // clear wins over a new link
    always_ff @(posedge clk) begin
        if (!rst_n || link_clear)
            link_bit <= 1'b0;
        else if (ll_take)
            link_bit <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (ll_take && !link_clear)
            link_addr <= acc.vaddr;
    end

    assign sc_ok = link_bit && (link_addr == acc.vaddr);

    // link only ever comes from an ll or an already held link
    a_sc_needs_link: assert property (@(posedge clk) disable iff (!rst_n)
        sc_ok |-> $past(ll_take) || $past(link_bit));

    // an exception or eret kills any pending sc
    a_clear_kills_sc: assert property (@(posedge clk) disable iff (!rst_n)
        link_clear |=> !sc_ok);

endmodule

// File: logic/mem1_stage.sv
`timescale 1ns/10ps

module mem1_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  mem_access_pkg::acc_req_t    acc,
    input  mem_access_pkg::tlb_result_t tlb,
    input  mem_access_pkg::cattr_t      k0_cattr,
    input  logic                        interrupt,
    input  logic                        prior_exc,
    input  mips_exc_pkg::exc_code_e     prior_code,
    input  logic                        eret,
    output mem_access_pkg::mem_req_t    mem_req,
    output mips_exc_pkg::exc_report_t   exc,
    output logic                        sc_success
);
    import mem_access_pkg::*;

    word_t     paddr;
    logic      uncached;
    logic      tlb_refill;
    logic      tlb_invalid;
    logic      tlb_modify;
    lane_out_t lanes [num_lanes];
    logic      sc_ok;
    logic      link_clear;

    addr_translate u_translate (
        .acc         (acc),
        .tlb         (tlb),
        .k0_cattr    (k0_cattr),
        .paddr       (paddr),
        .uncached    (uncached),
        .tlb_refill  (tlb_refill),
        .tlb_invalid (tlb_invalid),
        .tlb_modify  (tlb_modify)
    );

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        store_lane #(.lane_idx(i)) u_lane (
            .kind   (acc.kind),
            .offset (paddr[1:0]),
            .rt     (acc.rt),
            .lane   (lanes[i])
        );
    end

    ll_sc_monitor u_llsc (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc        (acc),
        .link_clear (link_clear),
        .sc_ok      (sc_ok)
    );

    access_commit u_commit (
        .clk         (clk),
        .rst_n       (rst_n),
        .acc         (acc),
        .interrupt   (interrupt),
        .prior_exc   (prior_exc),
        .prior_code  (prior_code),
        .eret        (eret),
        .paddr       (paddr),
        .uncached    (uncached),
        .tlb_refill  (tlb_refill),
        .tlb_invalid (tlb_invalid),
        .tlb_modify  (tlb_modify),
        .lanes       (lanes),
        .sc_ok       (sc_ok),
        .link_clear  (link_clear),
        .mem_req     (mem_req),
        .exc         (exc),
        .sc_success  (sc_success)
    );

endmodule

// File: logic/mem_access_pkg.sv
package mem_access_pkg;

    typedef logic [31:0] word_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;
    typedef logic [3:0]  strb_t;

    localparam int num_lanes = 4;

    typedef enum logic [3:0] {
        LB, LBU, LH, LHU, LW, LL,
        SB, SH, SW, SWL, SWR, SC
    } access_kind_e;

    typedef struct packed {
        logic         valid;
        access_kind_e kind;
        word_t        vaddr;
        word_t        pc;
        word_t        rt;     // store data
    } acc_req_t;

    typedef struct packed {
        logic   found;
        logic   valid;
        logic   dirty;
        pfn_t   pfn;
        cattr_t cattr;
    } tlb_result_t;

    typedef struct packed {
        logic       en;
        logic [7:0] data;
    } lane_out_t;

    typedef struct packed {
        logic       valid;
        logic       write;
        logic       uncached;
        logic [1:0] size;     // 0 byte, 1 half, 2 word
        word_t      paddr;
        strb_t      wstrb;
        word_t      wdata;
    } mem_req_t;

    function automatic logic is_store(access_kind_e kind);
        return kind inside {SB, SH, SW, SWL, SWR, SC};
    endfunction

    function automatic logic [1:0] access_size(access_kind_e kind);
        if (kind inside {LB, LBU, SB})
            return 2'd0;
        if (kind inside {LH, LHU, SH})
            return 2'd1;
        return 2'd2;   // word and partial word
    endfunction

endpackage

// File: logic/mips_exc_pkg.sv
package mips_exc_pkg;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_MOD  = 5'd1,
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5
    } exc_code_e;

    typedef struct packed {
        logic                  valid;
        exc_code_e             code;
        mem_access_pkg::word_t badvaddr;
        logic                  refill;   // tlb refill vector wanted
    } exc_report_t;

    // top three address bits of the unmapped segments
    localparam logic [2:0] seg_kseg0 = 3'b100;
    localparam logic [2:0] seg_kseg1 = 3'b101;

    localparam mem_access_pkg::cattr_t cattr_cacheable = 3'd3;

endpackage

// File: logic/store_lane.sv
`timescale 1ns/10ps

module store_lane #(
    parameter int lane_idx = 0
) (
    input  mem_access_pkg::access_kind_e kind,
    input  logic [1:0]                   offset,
    input  mem_access_pkg::word_t        rt,
    output mem_access_pkg::lane_out_t    lane
);
    import mem_access_pkg::*;

    localparam logic [1:0] idx = lane_idx[1:0];

    logic       en;
    logic [1:0] src;   // byte of rt feeding this lane

    always_comb begin
        en  = 1'b0;
        src = 2'd0;
        case (kind)
            SB: en = (offset == idx);
            SH: begin
                en  = (idx[1] == offset[1]);
                src = {1'b0, idx[0]};
            end
            SW, SC: begin
                en  = 1'b1;
                src = idx;
            end
            SWL: begin
                en  = (idx <= offset);
                src = 2'd3 - offset + idx;   // high bytes of rt
            end
            SWR: begin
                en  = (idx >= offset);
                src = idx - offset;
            end
            default: en = 1'b0;   // loads
        endcase
        assert (!en || is_store(kind))
            else $error("store_lane %0d enabled for load kind %s", lane_idx, kind.name());
    end

    assign lane.en   = en;
    assign lane.data = en ? rt[{src, 3'b000} +: 8] : 8'h00;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mem1_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module mem1_stage_tb -f compile.f \
    --Mdir obj_dir -o mem1_stage_sim \
    && ./obj_dir/mem1_stage_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "failure reported in sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
exit 0

// File: verification/mem1_stage_tb.sv
`timescale 1ns/10ps

module mem1_stage_tb;
    import mem_access_pkg::*;
    import mips_exc_pkg::*;

    typedef struct packed {
        mem_req_t    req;
        exc_report_t exc;
        logic        sc;
    } expect_t;

    localparam int n_directed = 65;
    localparam int n_random   = 400;
    localparam int max_cycles = n_directed + n_random + 50;

    logic        clk;
    logic        rst_n;
    acc_req_t    acc;
    tlb_result_t tlb;
    cattr_t      k0_cattr;
    logic        interrupt;
    logic        prior_exc;
    exc_code_e   prior_code;
    logic        eret;
    mem_req_t    mem_req;
    exc_report_t exc;
    logic        sc_success;

    expect_t     exp_q [$];
    string       name_q [$];
    logic        model_link;
    word_t       model_addr;
    logic [15:0] lfsr_state;
    int          errors;
    int          checks;
    int          cycles;

    mem1_stage DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc        (acc),
        .tlb        (tlb),
        .k0_cattr   (k0_cattr),
        .interrupt  (interrupt),
        .prior_exc  (prior_exc),
        .prior_code (prior_code),
        .eret       (eret),
        .mem_req    (mem_req),
        .exc        (exc),
        .sc_success (sc_success)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout: run went past %0d cycles", max_cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic word_t take_bits(input int n);
        word_t v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic expect_t predict(input acc_req_t a, input tlb_result_t t,
            input cattr_t k0, input logic irq, input logic pexc, input exc_code_e pcode,
            input logic lbit, input word_t laddr);
        expect_t e;
        logic    mapped;
        logic    store;
        logic    mis;
        logic    tlb_bad;
        logic    tlb_mod;
        logic    en;
        word_t   pa;
        int      o;
        int      src;
        e = '0;
        if (!a.valid)
            return e;
        mapped = !a.vaddr[31] || (a.vaddr[31:30] == 2'b11);
        store = a.kind inside {SB, SH, SW, SWL, SWR, SC};
        pa = mapped ? {t.pfn, a.vaddr[11:0]} : {3'b000, a.vaddr[28:0]};
        mis = 1'b0;
        if (a.kind inside {LH, LHU, SH})
            mis = a.vaddr[0];
        if (a.kind inside {LW, LL, SW, SC})
            mis = (a.vaddr[1:0] != 2'b00);
        tlb_bad = mapped && !(t.found && t.valid);
        tlb_mod = mapped && t.found && t.valid && !t.dirty && store;

        e.exc.valid    = 1'b1;
        e.exc.badvaddr = a.vaddr;
        if (irq) begin
            e.exc.code     = EXC_INT;
            e.exc.badvaddr = '0;
        end else if (pexc) begin
            e.exc.code     = pcode;
            e.exc.badvaddr = a.pc;
        end else if (mis && store) begin
            e.exc.code = EXC_ADES;
        end else if (mis) begin
            e.exc.code = EXC_ADEL;
        end else if (tlb_bad) begin
            e.exc.code   = store ? EXC_TLBS : EXC_TLBL;
            e.exc.refill = !t.found;
        end else if (tlb_mod) begin
            e.exc.code = EXC_MOD;
        end else begin
            e.exc = '0;
        end
        if (e.exc.valid)
            return e;
        if (a.kind == SC && !(lbit && laddr == a.vaddr))
            return e;   // failed sc, nothing on the bus

        e.sc        = (a.kind == SC);
        e.req.valid = 1'b1;
        e.req.write = store;
        e.req.paddr = pa;
        if (a.vaddr[31:29] == 3'b101)
            e.req.uncached = 1'b1;
        else if (a.vaddr[31:29] == 3'b100)
            e.req.uncached = (k0 != 3'd3);
        else
            e.req.uncached = (t.cattr != 3'd3);
        if (a.kind inside {LB, LBU, SB})
            e.req.size = 2'd0;
        else if (a.kind inside {LH, LHU, SH})
            e.req.size = 2'd1;
        else
            e.req.size = 2'd2;

        o = int'(pa[1:0]);
        for (int i = 0; i < 4; i++) begin
            en  = 1'b0;
            src = 0;
            case (a.kind)
                SB: en = (i == o);
                SH: begin
                    en  = (i / 2 == o / 2);
                    src = i % 2;
                end
                SW, SC: begin
                    en  = 1'b1;
                    src = i;
                end
                SWL: begin
                    en  = (i <= o);
                    src = 3 - o + i;
                end
                SWR: begin
                    en  = (i >= o);
                    src = i - o;
                end
                default: en = 1'b0;
            endcase
            if (en) begin
                e.req.wstrb[i]         = 1'b1;
                e.req.wdata[8*i +: 8]  = a.rt[8*src +: 8];
            end
        end
        return e;
    endfunction

    function automatic acc_req_t make_acc(input access_kind_e k, input word_t va,
            input word_t rt);
        acc_req_t a;
        a.valid = 1'b1;
        a.kind  = k;
        a.vaddr = va;
        a.pc    = {16'h0040, va[15:0]};
        a.rt    = rt;
        return a;
    endfunction

    function automatic tlb_result_t tlb_entry(input logic f, input logic v, input logic d,
            input pfn_t pfn, input cattr_t c);
        tlb_result_t t;
        t.found = f;
        t.valid = v;
        t.dirty = d;
        t.pfn   = pfn;
        t.cattr = c;
        return t;
    endfunction

    // one cycle of stimulus plus its expected outcome
    task automatic drive_cycle(input string name, input acc_req_t a, input tlb_result_t t,
            input cattr_t k0, input logic irq, input logic pexc, input exc_code_e pcode,
            input logic er);
        expect_t e;
        @(posedge clk);
        #2;
        acc        = a;
        tlb        = t;
        k0_cattr   = k0;
        interrupt  = irq;
        prior_exc  = pexc;
        prior_code = pcode;
        eret       = er;
        e = predict(a, t, k0, irq, pexc, pcode, model_link, model_addr);
        exp_q.push_back(e);
        name_q.push_back(name);
        if (e.exc.valid || er) begin
            model_link = 1'b0;
        end else if (a.valid && a.kind == LL) begin
            model_link = 1'b1;
            model_addr = a.vaddr;
        end
    endtask

    task automatic single_access(input string name, input access_kind_e k, input word_t va,
            input word_t rt, input tlb_result_t t);
        drive_cycle(name, make_acc(k, va, rt), t, 3'd3, 1'b0, 1'b0, EXC_INT, 1'b0);
    endtask

    task automatic idle_cycle(input string name, input logic er);
        drive_cycle(name, '0, '0, 3'd3, 1'b0, 1'b0, EXC_INT, er);
    endtask

    task automatic random_cycle(input int n);
        acc_req_t    a;
        tlb_result_t t;
        cattr_t      k0;
        word_t       r;
        logic [3:0]  k;
        logic [2:0]  c;
        logic [1:0]  seg;
        logic        irq;
        logic        pexc;
        logic        er;
        exc_code_e   pcode;
        a = '0;
        t = '0;
        r = take_bits(3);
        a.valid = (r[2:0] != 3'd0);
        r = take_bits(4);
        k = r[3:0];
        if (k > 4'd11)
            k = k - 4'd12;
        a.kind = access_kind_e'(k);
        r = take_bits(2);
        seg = r[1:0];
        a.vaddr = take_bits(32);
        case (seg)
            2'd0:    a.vaddr[31] = 1'b0;          // kuseg
            2'd1:    a.vaddr[31:29] = 3'b100;
            2'd2:    a.vaddr[31:29] = 3'b101;
            default: a.vaddr[31:30] = 2'b11;      // kseg2/3
        endcase
        r = take_bits(2);
        if (r[1:0] != 2'd0) begin   // mostly aligned
            if (a.kind inside {LW, LL, SW, SC})
                a.vaddr[1:0] = 2'b00;
            if (a.kind inside {LH, LHU, SH})
                a.vaddr[0] = 1'b0;
        end
        r = take_bits(1);
        if (a.kind == SC && model_link && r[0])
            a.vaddr = model_addr;
        a.pc = take_bits(32);
        a.rt = take_bits(32);
        r = take_bits(3);
        t.found = (r[2:0] != 3'd0);
        r = take_bits(3);
        t.valid = (r[2:0] != 3'd0);
        r = take_bits(1);
        t.dirty = r[0];
        r = take_bits(20);
        t.pfn = r[19:0];
        r = take_bits(4);
        t.cattr = r[3] ? 3'd3 : r[2:0];
        r = take_bits(4);
        k0 = r[3] ? 3'd3 : r[2:0];
        r = take_bits(5);
        irq = (r[4:0] == 5'd0);
        r = take_bits(5);
        pexc = (r[4:0] == 5'd0);
        r = take_bits(3);
        c = r[2:0];
        if (c > 3'd5)
            c = c - 3'd4;
        pcode = exc_code_e'({2'b00, c});
        r = take_bits(4);
        er = (r[3:0] == 4'd0);
        drive_cycle($sformatf("random_%0d", n), a, t, k0, irq, pexc, pcode, er);
    endtask

    // outputs of the access driven one edge earlier
    initial begin
        expect_t e;
        string   name;
        forever begin
            @(posedge clk);
            #1;
            if (exp_q.size() > 0) begin
                e    = exp_q.pop_front();
                name = name_q.pop_front();
                checks++;
                if (mem_req !== e.req) begin
                    errors++;
                    $display("[FAIL] %s mem_req expected %h actual %h", name, e.req, mem_req);
                end
                if (exc !== e.exc) begin
                    errors++;
                    $display("[FAIL] %s exc expected %h actual %h", name, e.exc, exc);
                end
                if (sc_success !== e.sc) begin
                    errors++;
                    $display("[FAIL] %s sc_success expected %b actual %b",
                             name, e.sc, sc_success);
                end
            end
        end
    end

    initial begin
        access_kind_e kd;
        tlb_result_t  plain;
        word_t        mva;
        word_t        lva;
        rst_n      = 1'b0;
        acc        = '0;
        tlb        = '0;
        k0_cattr   = 3'd3;
        interrupt  = 1'b0;
        prior_exc  = 1'b0;
        prior_code = EXC_INT;
        eret       = 1'b0;
        model_link = 1'b0;
        model_addr = '0;
        lfsr_state = 16'd78;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        plain = tlb_entry(1'b1, 1'b1, 1'b1, 20'h00000, 3'd3);
        mva   = 32'h0040_1004;
        lva   = 32'h8000_0200;
        acc   = make_acc(SW, 32'h8000_1000, 32'h0BAD_F00D);   // live store held in reset
        tlb   = plain;
        repeat (2) @(posedge clk);
        #2;
        checks++;
        if (mem_req.valid || exc.valid || sc_success) begin
            errors++;
            $display("[FAIL] reset_outputs expected 000 actual %b%b%b",
                     mem_req.valid, exc.valid, sc_success);
        end
        rst_n = 1'b1;
        acc   = '0;

        idle_cycle("reset_idle", 1'b0);

        drive_cycle("kseg0_cached", make_acc(LW, 32'h8000_1000, 32'h0), plain, 3'd3,
                    1'b0, 1'b0, EXC_INT, 1'b0);
        drive_cycle("kseg0_uncached", make_acc(LW, 32'h8000_1000, 32'h0), plain, 3'd2,
                    1'b0, 1'b0, EXC_INT, 1'b0);
        single_access("kseg1", LW, 32'hA000_2004, 32'h0, plain);
        single_access("kuseg_mapped", SW, 32'h0040_3008, 32'h1234_5678,
                      tlb_entry(1'b1, 1'b1, 1'b1, 20'hABCDE, 3'd3));
        single_access("kseg2_uncached", LH, 32'hC000_500E, 32'h0,
                      tlb_entry(1'b1, 1'b1, 1'b1, 20'h0F0F0, 3'd2));

        for (int k = 6; k < 12; k++) begin
            kd = access_kind_e'(k[3:0]);
            for (int o = 0; o < 4; o++) begin
                if (kd == SC)
                    single_access($sformatf("ll_off%0d", o), LL, 32'h8000_0100 + o, 32'h0, plain);
                single_access($sformatf("store_%s_off%0d", kd.name(), o), kd,
                              32'h8000_0100 + o, 32'hA1B2_C3D4, plain);
            end
        end
        for (int k = 0; k < 6; k++) begin
            kd = access_kind_e'(k[3:0]);
            single_access($sformatf("load_%s", kd.name()), kd, 32'h8000_0300, 32'h0, plain);
        end

        single_access("adel_lh_odd", LH, 32'h8000_0401, 32'h0, plain);
        single_access("adel_lw_off2", LW, 32'h8000_0402, 32'h0, plain);
        single_access("adel_ll_off3", LL, 32'h8000_0403, 32'h0, plain);

        single_access("tlbl_refill", LW, mva, 32'h0, tlb_entry(1'b0, 1'b0, 1'b0, 20'h12345, 3'd3));
        single_access("tlbl_invalid", LW, mva, 32'h0, tlb_entry(1'b1, 1'b0, 1'b1, 20'h12345, 3'd3));
        single_access("tlbs_refill", SW, mva, 32'h5555_AAAA,
                      tlb_entry(1'b0, 1'b0, 1'b0, 20'h12345, 3'd3));
        single_access("tlb_modify", SW, mva, 32'h5555_AAAA,
                      tlb_entry(1'b1, 1'b1, 1'b0, 20'h12345, 3'd3));
        single_access("clean_load", LW, mva, 32'h0, tlb_entry(1'b1, 1'b1, 1'b0, 20'h12345, 3'd3));
        drive_cycle("irq_over_modify", make_acc(SW, mva, 32'h1),
                    tlb_entry(1'b1, 1'b1, 1'b0, 20'h12345, 3'd3), 3'd3,
                    1'b1, 1'b0, EXC_INT, 1'b0);
        drive_cycle("prior_over_refill", make_acc(SW, mva, 32'h1),
                    tlb_entry(1'b0, 1'b0, 1'b0, 20'h12345, 3'd3), 3'd3,
                    1'b0, 1'b1, EXC_TLBL, 1'b0);
        drive_cycle("irq_over_prior", make_acc(LW, mva, 32'h0), plain, 3'd3,
                    1'b1, 1'b1, EXC_MOD, 1'b0);
        single_access("ades_over_tlbs", SW, mva + 32'd2, 32'h1,
                      tlb_entry(1'b0, 1'b0, 1'b0, 20'h12345, 3'd3));

        single_access("ll_a", LL, lva, 32'h0, plain);
        single_access("sc_same", SC, lva, 32'hCAFE_0001, plain);
        single_access("ll_b", LL, lva, 32'h0, plain);
        single_access("sc_other", SC, lva + 32'd4, 32'hCAFE_0002, plain);
        single_access("ll_c", LL, lva, 32'h0, plain);
        idle_cycle("eret_pulse", 1'b1);
        single_access("sc_after_eret", SC, lva, 32'hCAFE_0003, plain);
        single_access("ll_d", LL, lva, 32'h0, plain);
        single_access("exc_kills_link", LW, lva + 32'd1, 32'h0, plain);
        single_access("sc_after_exc", SC, lva, 32'hCAFE_0004, plain);
        single_access("ll_e", LL, lva, 32'h0, plain);
        drive_cycle("sc_with_irq", make_acc(SC, lva, 32'hCAFE_0005), plain, 3'd3,
                    1'b1, 1'b0, EXC_INT, 1'b0);

        for (int n = 0; n < n_random; n++)
            random_cycle(n);

        idle_cycle("final_idle", 1'b0);
        @(posedge clk);
        #3;
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results were never compared", exp_q.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
